//--- source/ooo_pkg.sv
// Shared widths, operation codes and bus structs for the out-of-order backend
// Every RTL block imports this package and the testbench uses the same types
package ooo_pkg;

    localparam int data_width     = 32;
    localparam int reg_count      = 16;
    localparam int rob_depth      = 8;
    localparam int rs_count       = 4;
    localparam int tag_width      = $clog2(rob_depth);
    localparam int reg_addr_width = $clog2(reg_count);

    // A li is finished at dispatch, beq redirects when its operands match
    typedef enum logic [2:0] {
        op_li,
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_beq
    } rob_op_t;

    // Decoded instruction where imm doubles as the branch target for beq
    typedef struct packed {
        rob_op_t                   op;
        logic [reg_addr_width-1:0] rdest;
        logic [reg_addr_width-1:0] rsrc1;
        logic [reg_addr_width-1:0] rsrc2;
        logic [data_width-1:0]     iaddr;
        logic [data_width-1:0]     imm;
    } inst_t;

    // A source operand is either ready with data or waiting on a tag
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [tag_width-1:0]  tag;
        logic                  rdy;
    } operand_t;

    typedef struct packed {
        rob_op_t               op;
        logic [tag_width-1:0]  tag;
        operand_t [1:0]        src;
        logic [data_width-1:0] imm;
    } issue_t;

    // Common data bus broadcast
    typedef struct packed {
        logic                  en;
        logic [tag_width-1:0]  tag;
        logic [data_width-1:0] data;
        logic                  redirect;
        logic [data_width-1:0] addr;
    } cdb_t;

    typedef struct packed {
        logic                      en;
        logic [reg_addr_width-1:0] rdest;
        logic [data_width-1:0]     data;
        logic [data_width-1:0]     iaddr;
    } retire_t;

endpackage

//--- source/register_map.sv
// Architectural register file with a rename tag and ready bit per register
// Renamed by the dispatcher, written back by the re-order buffer at retirement
module register_map (
    input  logic                               clk,
    input  logic                               n_rst,
    input  logic [ooo_pkg::reg_addr_width-1:0] rsrc [2],
    output ooo_pkg::operand_t                  src_map [2],
    input  logic                               tag_wr_en,
    input  logic [ooo_pkg::reg_addr_width-1:0] tag_wr_rdest,
    input  logic [ooo_pkg::tag_width-1:0]      tag_wr_tag,
    input  ooo_pkg::retire_t                   retire,
    input  logic [ooo_pkg::tag_width-1:0]      retire_tag,
    input  logic                               flush
);
    import ooo_pkg::*;

    logic [data_width-1:0] reg_data [reg_count];
    logic [tag_width-1:0]  reg_tag  [reg_count];
    logic                  reg_rdy  [reg_count];

    // Both source lookups are answered in the same cycle
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src_map[i].data = reg_data[rsrc[i]];
            src_map[i].tag  = reg_tag[rsrc[i]];
            src_map[i].rdy  = reg_rdy[rsrc[i]];
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < reg_count; i++) begin
                reg_data[i] <= '0;
                reg_tag[i]  <= '0;
                reg_rdy[i]  <= 1'b1;
            end
        end else begin
            if (retire.en) begin
                reg_data[retire.rdest] <= retire.data;
            end
            for (int i = 0; i < reg_count; i++) begin
                // After a flush nothing is in flight, so the stored values are the truth
                if (flush) begin
                    reg_rdy[i] <= 1'b1;
                end else if (tag_wr_en && tag_wr_rdest == reg_addr_width'(i)) begin
                    reg_tag[i] <= tag_wr_tag;
                    reg_rdy[i] <= 1'b0;
                end else if (retire.en && retire.rdest == reg_addr_width'(i)
                             && reg_tag[i] == retire_tag) begin
                    // Only the youngest writer of a register may mark it ready
                    reg_rdy[i] <= 1'b1;
                end
            end
        end
    end

endmodule

//--- source/reorder_buffer.sv
// Circular buffer of in-flight instructions that retires them in program order
// It also resolves source operands at dispatch and flushes on a taken branch
module reorder_buffer (
    input  logic                           clk,
    input  logic                           n_rst,
    input  logic                           alloc_en,
    input  ooo_pkg::inst_t                 inst,
    output logic [ooo_pkg::tag_width-1:0]  tail_tag,
    output logic                           full,
    input  ooo_pkg::operand_t              src_map [2],
    output ooo_pkg::operand_t              src_lookup [2],
    input  ooo_pkg::cdb_t                  cdb,
    output ooo_pkg::retire_t               retire,
    output logic [ooo_pkg::tag_width-1:0]  retire_tag,
    output logic                           redirect,
    output logic [ooo_pkg::data_width-1:0] redirect_addr
);
    import ooo_pkg::*;

    // One in-flight instruction whose addr holds the branch target
    typedef struct packed {
        logic                      rdy;
        logic                      redirect;
        logic [data_width-1:0]     addr;
        logic [data_width-1:0]     data;
        logic [data_width-1:0]     iaddr;
        logic [reg_addr_width-1:0] rdest;
    } rob_entry_t;

    rob_entry_t entries [rob_depth];

    // Pointers carry an extra wrap bit to tell full from empty
    logic [tag_width:0]   head;
    logic [tag_width:0]   tail;
    logic [tag_width-1:0] head_addr;
    logic [tag_width-1:0] tail_addr;
    logic                 empty;
    logic                 head_done;
    rob_entry_t           head_entry;

    assign head_addr = head[tag_width-1:0];
    assign tail_addr = tail[tag_width-1:0];
    assign empty     = (head == tail);
    assign full      = (tail == {~head[tag_width], head_addr});
    assign tail_tag  = tail_addr;

    assign head_entry = entries[head_addr];
    assign head_done  = head_entry.rdy && !empty;

    // A finished head either retires or, as a taken branch, flushes everything
    assign redirect      = head_done && head_entry.redirect;
    assign redirect_addr = head_entry.addr;
    assign retire.en     = head_done && !head_entry.redirect;
    assign retire.rdest  = head_entry.rdest;
    assign retire.data   = head_entry.data;
    assign retire.iaddr  = head_entry.iaddr;
    assign retire_tag    = head_addr;

    // Ready register data wins, then a same-cycle broadcast, then the entry itself
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (src_map[i].rdy) begin
                src_lookup[i] = src_map[i];
            end else if (cdb.en && cdb.tag == src_map[i].tag) begin
                src_lookup[i].data = cdb.data;
                src_lookup[i].tag  = cdb.tag;
                src_lookup[i].rdy  = 1'b1;
            end else begin
                src_lookup[i].data = entries[src_map[i].tag].data;
                src_lookup[i].tag  = src_map[i].tag;
                src_lookup[i].rdy  = entries[src_map[i].tag].rdy;
            end
        end
    end

    // Dispatch fills the tail entry, otherwise a broadcast completes its entry
    always_ff @(posedge clk) begin
        for (int i = 0; i < rob_depth; i++) begin
            if (alloc_en && tail_addr == tag_width'(i)) begin
                entries[i].rdy      <= (inst.op == op_li);
                entries[i].redirect <= 1'b0;
                entries[i].addr     <= inst.imm;
                entries[i].data     <= inst.imm;
                entries[i].iaddr    <= inst.iaddr;
                entries[i].rdest    <= inst.rdest;
            end else if (cdb.en && cdb.tag == tag_width'(i)) begin
                entries[i].rdy      <= 1'b1;
                entries[i].redirect <= cdb.redirect;
                entries[i].addr     <= cdb.addr;
                entries[i].data     <= cdb.data;
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            head <= '0;
            tail <= '0;
        end else if (redirect) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (alloc_en) begin
                tail <= tail + 1'b1;
            end
            if (retire.en) begin
                head <= head + 1'b1;
            end
        end
    end

endmodule

//--- source/dispatcher.sv
// Accepts one decoded instruction per cycle and hands it to a free station
// Back-pressure comes from a full buffer, busy stations or a flush
module dispatcher (
    input  logic                               clk,
    input  logic                               n_rst,
    input  ooo_pkg::inst_t                     inst,
    input  logic                               inst_valid,
    output logic                               inst_ready,
    input  logic                               rob_full,
    input  logic [ooo_pkg::tag_width-1:0]      rob_tag,
    input  ooo_pkg::operand_t                  src_lookup [2],
    output logic [ooo_pkg::reg_addr_width-1:0] rsrc [2],
    input  logic [ooo_pkg::rs_count-1:0]       rs_busy,
    output ooo_pkg::issue_t                    issue,
    output logic [ooo_pkg::rs_count-1:0]       issue_en,
    output logic                               alloc_en,
    input  logic                               flush
);
    import ooo_pkg::*;

    logic                started;
    logic                is_li;
    logic                any_free;
    logic [rs_count-1:0] free_sel;

    // Holds off the first cycle after reset
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    // Lowest-numbered idle station wins
    always_comb begin
        free_sel = '0;
        for (int i = rs_count - 1; i >= 0; i--) begin
            if (!rs_busy[i]) begin
                free_sel    = '0;
                free_sel[i] = 1'b1;
            end
        end
    end

    assign any_free = |free_sel;
    assign is_li    = (inst.op == op_li);

    // A li never needs a station since it finishes in the buffer
    assign inst_ready = started && !rob_full && !flush && (is_li || any_free);
    assign alloc_en   = inst_valid && inst_ready;
    assign issue_en   = (alloc_en && !is_li) ? free_sel : '0;

    assign rsrc[0] = inst.rsrc1;
    assign rsrc[1] = inst.rsrc2;

    assign issue.op     = inst.op;
    assign issue.tag    = rob_tag;
    assign issue.src[0] = src_lookup[0];
    assign issue.src[1] = src_lookup[1];
    assign issue.imm    = inst.imm;

endmodule

//--- source/reservation_station.sv
// One reservation station that waits for operands, executes and holds its result
// The result stays on offer to the data bus arbiter until it is granted
module reservation_station (
    input  logic            clk,
    input  logic            n_rst,
    input  ooo_pkg::issue_t issue,
    input  logic            issue_en,
    input  ooo_pkg::cdb_t   cdb,
    input  logic            grant,
    input  logic            flush,
    output logic            busy,
    output logic            done,
    output ooo_pkg::cdb_t   result
);
    import ooo_pkg::*;

    rob_op_t               op;
    logic [tag_width-1:0]  tag;
    operand_t [1:0]        src;
    logic [data_width-1:0] imm;
    logic                  operands_rdy;

    // The result is computed from the held operands and then registered
    logic [data_width-1:0] alu_data;
    logic                  alu_redirect;
    logic [data_width-1:0] res_data;
    logic                  res_redirect;
    logic [data_width-1:0] res_addr;

    assign operands_rdy = src[0].rdy && src[1].rdy;

    always_comb begin
        alu_data     = '0;
        alu_redirect = 1'b0;
        case (op)
            op_add:  alu_data = src[0].data + src[1].data;
            op_sub:  alu_data = src[0].data - src[1].data;
            op_and:  alu_data = src[0].data & src[1].data;
            op_xor:  alu_data = src[0].data ^ src[1].data;
            // Branch writes zero and redirects only when taken
            op_beq:  alu_redirect = (src[0].data == src[1].data);
            default: alu_data = '0;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (flush || grant) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (issue_en) begin
            busy <= 1'b1;
            done <= 1'b0;
        end else if (busy && operands_rdy) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_en) begin
            op  <= issue.op;
            tag <= issue.tag;
            src <= issue.src;
            imm <= issue.imm;
        end else begin
            // Snoop the bus for any operand still waiting on its tag
            for (int i = 0; i < 2; i++) begin
                if (!src[i].rdy && cdb.en && cdb.tag == src[i].tag) begin
                    src[i].data <= cdb.data;
                    src[i].rdy  <= 1'b1;
                end
            end
        end
        if (busy && operands_rdy && !done) begin
            res_data     <= alu_data;
            res_redirect <= alu_redirect;
            res_addr     <= imm;
        end
    end

    // The arbiter supplies the enable for whichever station it picks
    assign result.en       = 1'b0;
    assign result.tag      = tag;
    assign result.data     = res_data;
    assign result.redirect = res_redirect;
    assign result.addr     = res_addr;

endmodule

//--- source/cdb_arbiter.sv
// Picks one finished station per cycle and drives its result on the data bus
// Fixed priority lets the lowest-numbered station always win
module cdb_arbiter (
    input  logic [ooo_pkg::rs_count-1:0] done,
    input  ooo_pkg::cdb_t                results [ooo_pkg::rs_count],
    output logic [ooo_pkg::rs_count-1:0] grant,
    output ooo_pkg::cdb_t                cdb
);
    import ooo_pkg::*;

    // Scanning downward lets the lowest done station overwrite the others
    always_comb begin
        grant = '0;
        cdb   = '0;
        for (int i = rs_count - 1; i >= 0; i--) begin
            if (done[i]) begin
                grant    = '0;
                grant[i] = 1'b1;
                cdb      = results[i];
                cdb.en   = 1'b1;
            end
        end
    end

endmodule

//--- source/ooo_core.sv
// Top level of the out-of-order backend
// Connects dispatch, renaming, the re-order buffer and the station bank
module ooo_core (
    input  logic                           clk,
    input  logic                           n_rst,
    input  ooo_pkg::inst_t                 inst,
    input  logic                           inst_valid,
    output logic                           inst_ready,
    output ooo_pkg::retire_t               retire,
    output logic                           redirect,
    output logic [ooo_pkg::data_width-1:0] redirect_addr
);
    import ooo_pkg::*;

    logic [reg_addr_width-1:0] rsrc [2];
    operand_t                  src_map [2];
    operand_t                  src_lookup [2];
    logic                      rob_full;
    logic [tag_width-1:0]      rob_tag;
    logic [tag_width-1:0]      retire_tag;
    logic                      alloc_en;
    issue_t                    issue;
    logic [rs_count-1:0]       issue_en;
    logic [rs_count-1:0]       rs_busy;
    logic [rs_count-1:0]       rs_done;
    logic [rs_count-1:0]       rs_grant;
    cdb_t                      rs_result [rs_count];
    cdb_t                      cdb;

    dispatcher u_dispatcher (
        .clk        (clk),
        .n_rst      (n_rst),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .rob_full   (rob_full),
        .rob_tag    (rob_tag),
        .src_lookup (src_lookup),
        .rsrc       (rsrc),
        .rs_busy    (rs_busy),
        .issue      (issue),
        .issue_en   (issue_en),
        .alloc_en   (alloc_en),
        .flush      (redirect)
    );

    // The rename write targets the destination with the freshly allocated tag
    register_map u_register_map (
        .clk          (clk),
        .n_rst        (n_rst),
        .rsrc         (rsrc),
        .src_map      (src_map),
        .tag_wr_en    (alloc_en),
        .tag_wr_rdest (inst.rdest),
        .tag_wr_tag   (rob_tag),
        .retire       (retire),
        .retire_tag   (retire_tag),
        .flush        (redirect)
    );

    reorder_buffer u_reorder_buffer (
        .clk           (clk),
        .n_rst         (n_rst),
        .alloc_en      (alloc_en),
        .inst          (inst),
        .tail_tag      (rob_tag),
        .full          (rob_full),
        .src_map       (src_map),
        .src_lookup    (src_lookup),
        .cdb           (cdb),
        .retire        (retire),
        .retire_tag    (retire_tag),
        .redirect      (redirect),
        .redirect_addr (redirect_addr)
    );

    cdb_arbiter u_cdb_arbiter (
        .done    (rs_done),
        .results (rs_result),
        .grant   (rs_grant),
        .cdb     (cdb)
    );

    for (genvar i = 0; i < rs_count; i++) begin : g_rs
        reservation_station u_rs (
            .clk      (clk),
            .n_rst    (n_rst),
            .issue    (issue),
            .issue_en (issue_en[i]),
            .cdb      (cdb),
            .grant    (rs_grant[i]),
            .flush    (redirect),
            .busy     (rs_busy[i]),
            .done     (rs_done[i]),
            .result   (rs_result[i])
        );
    end

endmodule

//--- tb/tb_checks.svh
// Driver, random source and compare tasks for the out-of-order backend testbench
// Included inside the testbench module body, so it uses that module's signals
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

    // Galois LFSR state for the polynomial x^32 + x^22 + x^2 + x + 1
    logic [31:0] lfsr_state = 32'hff90_c6e1;

    // Takes n bits from the LFSR and steps it once for every bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return r;
    endfunction

    // One of the four ALU operations, picked at random
    function automatic rob_op_t alu_op();
        logic [1:0] pick;
        pick = 2'(rand_bits(2));
        case (pick)
            2'd0:    return op_add;
            2'd1:    return op_sub;
            2'd2:    return op_and;
            default: return op_xor;
        endcase
    endfunction

    // Holds one instruction on the input until the core takes it
    // Called just after a rising edge and returns just after one
    task automatic send_inst(input rob_op_t op, input int rd, input int s1, input int s2,
                             input logic [data_width-1:0] imm);
        inst_t i;
        logic  accepted;
        i.op    = op;
        i.rdest = reg_addr_width'(rd);
        i.rsrc1 = reg_addr_width'(s1);
        i.rsrc2 = reg_addr_width'(s2);
        i.iaddr = pc;
        i.imm   = imm;
        pc = pc + 4;
        inst       = i;
        inst_valid = 1'b1;
        accepted   = 1'b0;
        while (!accepted) begin
            // The handshake is settled by the falling edge and holds until the next rise
            @(negedge clk);
            accepted = inst_ready;
            @(posedge clk);
            #1;
        end
        inst_valid = 1'b0;
        model_step(i);
    endtask

    task automatic check_retire(input retire_t exp, input retire_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s: retire expected r%0d=%h iaddr %h, got r%0d=%h iaddr %h",
                     test_name, exp.rdest, exp.data, exp.iaddr,
                     act.rdest, act.data, act.iaddr);
        end
    endtask

    task automatic check_redirect(input logic [data_width-1:0] exp,
                                  input logic [data_width-1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s: redirect expected %h, got %h", test_name, exp, act);
        end
    endtask

    task automatic check_condition(input logic ok, input string what_failed);
        if (ok !== 1'b1) begin
            other_errors++;
            $display("Test %s: %s", test_name, what_failed);
        end
    endtask

`endif

//--- tb/tb_ooo_core.sv
// Testbench for the out-of-order backend
// Streams directed programs into the core and checks every retirement and
// redirect against an in-order model of the same programs
module tb_ooo_core;
    import ooo_pkg::*;

    // Number of instructions each test sends
    localparam int n_li        = 12;
    localparam int n_chain     = 28;
    localparam int n_ooo       = 26;
    localparam int n_stream    = 48;
    localparam int n_taken     = 10;
    localparam int n_not_taken = 7;
    localparam int total_insts = n_li + n_chain + n_ooo + n_stream + n_taken + n_not_taken;

    logic                  clk;
    logic                  n_rst;
    inst_t                 inst;
    logic                  inst_valid;
    logic                  inst_ready;
    retire_t               retire;
    logic                  redirect;
    logic [data_width-1:0] redirect_addr;

    // In-order reference state and the results it still expects
    logic [data_width-1:0] model_regs [reg_count];
    retire_t               exp_retire [$];
    logic [data_width-1:0] exp_redirect [$];
    // Set between a taken branch and its redirect, younger instructions are squashed
    logic                  wrong_path = 1'b0;
    logic [data_width-1:0] pc = 32'h0000_0100;
    string                 test_name = "reset";
    int                    value_errors = 0;
    int                    missing_errors = 0;
    int                    other_errors = 0;
    int                    stall_cycles = 0;

    `include "tb_checks.svh"

    ooo_core uut (
        .clk           (clk),
        .n_rst         (n_rst),
        .inst          (inst),
        .inst_valid    (inst_valid),
        .inst_ready    (inst_ready),
        .retire        (retire),
        .redirect      (redirect),
        .redirect_addr (redirect_addr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Ends a stuck run after 200 cycles for every instruction of all tests
    initial begin
        repeat (200 * total_insts) @(posedge clk);
        $display("Watchdog expired with %0d retirements still expected in test %s",
                 exp_retire.size(), test_name);
        $display("TEST FAILED");
        $finish;
    end

    // Outputs are sampled at the falling edge where they are settled
    always @(negedge clk) begin
        if (n_rst) begin
            if (inst_valid && !inst_ready) begin
                stall_cycles++;
            end
            if (retire.en) begin
                if (exp_retire.size() == 0) begin
                    other_errors++;
                    $display("Test %s: unexpected retirement to r%0d from iaddr %h",
                             test_name, retire.rdest, retire.iaddr);
                end else begin
                    check_retire(exp_retire.pop_front(), retire);
                end
            end
            if (redirect) begin
                if (exp_redirect.size() == 0) begin
                    other_errors++;
                    $display("Test %s: unexpected redirect to %h", test_name, redirect_addr);
                end else begin
                    check_redirect(exp_redirect.pop_front(), redirect_addr);
                end
                wrong_path = 1'b0;
            end
        end
    end

    // Executes one accepted instruction in program order
    task automatic model_step(input inst_t i);
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        logic [data_width-1:0] val;
        retire_t               r;
        a = model_regs[i.rsrc1];
        b = model_regs[i.rsrc2];
        case (i.op)
            op_li:   val = i.imm;
            op_add:  val = a + b;
            op_sub:  val = a - b;
            op_and:  val = a & b;
            op_xor:  val = a ^ b;
            default: val = '0;
        endcase
        if (wrong_path) begin
            // Squashed by the pending flush so nothing is expected
        end else if (i.op == op_beq && a == b) begin
            exp_redirect.push_back(i.imm);
            wrong_path = 1'b1;
        end else begin
            // A branch that falls through writes zero to its destination
            model_regs[i.rdest] = val;
            r.en    = 1'b1;
            r.rdest = i.rdest;
            r.data  = val;
            r.iaddr = i.iaddr;
            exp_retire.push_back(r);
        end
    endtask

    // Waits until everything the model expects has been seen
    task automatic drain(input int budget);
        int waited;
        waited = 0;
        while ((exp_retire.size() != 0 || exp_redirect.size() != 0)
               && waited < 200 * budget) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_retire.size() != 0 || exp_redirect.size() != 0) begin
            missing_errors += exp_retire.size() + exp_redirect.size();
            $display("Test %s: %0d retirements and %0d redirects never arrived",
                     test_name, exp_retire.size(), exp_redirect.size());
            exp_retire.delete();
            exp_redirect.delete();
            wrong_path = 1'b0;
        end
    endtask

    task automatic test_li();
        test_name = "li_in_order";
        for (int k = 0; k < n_li; k++) begin
            send_inst(op_li, rand_bits(4), 0, 0, rand_bits(32));
        end
        drain(n_li);
    endtask

    // Only four registers, so most operands come from the bus or the buffer
    task automatic test_alu_chain();
        test_name = "alu_chain";
        for (int k = 0; k < 4; k++) begin
            send_inst(op_li, k, 0, 0, rand_bits(32));
        end
        for (int k = 4; k < n_chain; k++) begin
            send_inst(alu_op(), rand_bits(2), rand_bits(2), rand_bits(2), '0);
        end
        drain(n_chain);
    endtask

    // The xor is ready at issue and finishes ahead of the waiting sub
    task automatic test_out_of_order();
        test_name = "out_of_order";
        send_inst(op_li, 4, 0, 0, rand_bits(32));
        send_inst(op_li, 5, 0, 0, rand_bits(32));
        for (int k = 0; k < (n_ooo - 2) / 4; k++) begin
            send_inst(op_add, 6, 4, 5, '0);
            send_inst(op_sub, 7, 6, 4, '0);
            send_inst(op_xor, 8, 4, 5, '0);
            send_inst(op_add, 5, 7, 8, '0);
        end
        drain(n_ooo);
    endtask

    task automatic test_stream();
        test_name = "stream_stall";
        stall_cycles = 0;
        for (int k = 0; k < n_stream; k++) begin
            if (rand_bits(2) == 0) begin
                send_inst(op_li, rand_bits(2), 0, 0, rand_bits(32));
            end else begin
                send_inst(alu_op(), rand_bits(2), rand_bits(2), rand_bits(2), '0);
            end
        end
        drain(n_stream);
        check_condition(stall_cycles > 0, "the stream never stalled on inst_ready");
    endtask

    // The branch waits on r10 long enough for the three wrong-path li to enter
    task automatic test_branch_taken();
        logic [data_width-1:0] v;
        test_name = "branch_taken";
        v = rand_bits(32);
        send_inst(op_li, 8, 0, 0, v);
        send_inst(op_li, 9, 0, 0, v);
        send_inst(op_li, 2, 0, 0, rand_bits(32));
        send_inst(op_and, 10, 8, 8, '0);
        send_inst(op_beq, 12, 10, 9, 32'h0000_2000);
        send_inst(op_li, 0, 0, 0, 32'hdead_0000);
        send_inst(op_li, 1, 0, 0, 32'hdead_0001);
        send_inst(op_li, 12, 0, 0, 32'hdead_0012);
        // These read registers the squashed path tried to write
        send_inst(op_xor, 13, 0, 1, '0);
        send_inst(op_add, 14, 12, 10, '0);
        drain(n_taken);
    endtask

    task automatic test_branch_not_taken();
        logic [data_width-1:0] v;
        test_name = "branch_not_taken";
        v = rand_bits(32);
        send_inst(op_li, 8, 0, 0, v);
        send_inst(op_li, 9, 0, 0, v ^ 32'h1);
        send_inst(op_beq, 12, 8, 9, 32'h0000_3000);
        send_inst(op_add, 13, 12, 8, '0);
        send_inst(op_sub, 14, 9, 12, '0);
        send_inst(op_li, 15, 0, 0, rand_bits(32));
        send_inst(op_xor, 12, 12, 15, '0);
        drain(n_not_taken);
    endtask

    initial begin
        n_rst      = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        for (int k = 0; k < reg_count; k++) begin
            model_regs[k] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        n_rst = 1'b1;
        // The dispatcher holds off for one cycle after reset
        @(negedge clk);
        check_condition(!inst_ready && !retire.en && !redirect,
                        "outputs were not quiet in the first cycle after reset");
        @(posedge clk);
        #1;
        test_li();
        test_alu_chain();
        test_out_of_order();
        test_stream();
        test_branch_taken();
        test_branch_not_taken();
        $display("Errors: %0d wrong values, %0d missing results, %0d other",
                 value_errors, missing_errors, other_errors);
        if (value_errors + missing_errors + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+tb
source/ooo_pkg.sv
source/register_map.sv
source/reorder_buffer.sv
source/dispatcher.sv
source/reservation_station.sv
source/cdb_arbiter.sv
source/ooo_core.sv
tb/tb_ooo_core.sv
